/* files.f */
+incdir+bench
verilog/simd_alu_pkg.sv
verilog/alu_csr.sv
verilog/alu_issue_ctrl.sv
verilog/alu_arith.sv
verilog/alu_compare.sv
verilog/alu_logic_shift.sv
verilog/simd_alu_top.sv
bench/tb_simd_alu.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert
TOP       ?= tb_simd_alu
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir

.PHONY: sim clean

# Pass only when the simulation prints the pass line
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^TEST OK$$"

clean:
	rm -rf $(OBJ_DIR)

/* bench/alu_ref.svh */
//////////////////////////////////////////////////
// Expected results of the SIMD ALU, lane by lane
// Included inside the testbench module. Lanes are
// 8 << vew bits wide; shifts use log2 of that width.
//////////////////////////////////////////////////
`ifndef ALU_REF_SVH
`define ALU_REF_SVH

function automatic simd_alu_pkg::alu_res_t ref_result(
  input simd_alu_pkg::alu_op_e op,
  input simd_alu_pkg::vew_e    vew,
  input logic [63:0]           a,
  input logic [63:0]           b
);
  int unsigned            w, sh;
  logic [63:0]            mask, ua, ub, r;
  logic [64:0]            u;
  logic signed [65:0]     sa, sb, t, smax, smin;
  logic                   sat;
  simd_alu_pkg::alu_res_t res;
  res  = '0;
  w    = 8 << vew;
  mask = (w == 64) ? '1 : (64'd1 << w) - 64'd1;
  smax = (66'sd1 <<< (w - 1)) - 66'sd1;
  smin = -(66'sd1 <<< (w - 1));
  for (int l = 0; l < 64 / w; l++) begin
    ua  = (a >> (l * w)) & mask;
    ub  = (b >> (l * w)) & mask;
    // Sign extended lane values
    sa  = ua[w-1] ? $signed({2'b11, ua | ~mask}) : $signed({2'b00, ua});
    sb  = ub[w-1] ? $signed({2'b11, ub | ~mask}) : $signed({2'b00, ub});
    sh  = int'(ua[5:0]) % w;
    sat = 1'b0;
    r   = '0;
    case (op)
      simd_alu_pkg::AND:   r = ua & ub;
      simd_alu_pkg::OR:    r = ua | ub;
      simd_alu_pkg::XOR:   r = ua ^ ub;
      simd_alu_pkg::ADD:   r = ua + ub;
      simd_alu_pkg::SUB:   r = ub - ua;
      simd_alu_pkg::RSUB:  r = ua - ub;
      simd_alu_pkg::SADDU: begin
        u   = ua + ub;
        sat = u > {1'b0, mask};
        r   = sat ? mask : u[63:0];
      end
      simd_alu_pkg::SSUBU: begin
        sat = ub < ua;
        r   = sat ? '0 : ub - ua;
      end
      simd_alu_pkg::SADD, simd_alu_pkg::SSUB: begin
        t   = (op == simd_alu_pkg::SADD) ? sa + sb : sb - sa;
        sat = (t > smax) || (t < smin);
        if (t > smax) begin
          r = smax[63:0];
        end else if (t < smin) begin
          r = smin[63:0];
        end else begin
          r = t[63:0];
        end
      end
      simd_alu_pkg::SLL:   r = ub << sh;
      simd_alu_pkg::SRL:   r = ub >> sh;
      simd_alu_pkg::SRA: begin
        t = sb >>> sh;
        r = t[63:0];
      end
      simd_alu_pkg::MIN:   r = (sb < sa) ? ub : ua;
      simd_alu_pkg::MINU:  r = (ub < ua) ? ub : ua;
      simd_alu_pkg::MAX:   r = (sb < sa) ? ua : ub;
      simd_alu_pkg::MAXU:  r = (ub < ua) ? ua : ub;
      simd_alu_pkg::MSEQ:  r = {63'd0, ub == ua};
      simd_alu_pkg::MSNE:  r = {63'd0, ub != ua};
      simd_alu_pkg::MSLT:  r = {63'd0, sb < sa};
      simd_alu_pkg::MSLTU: r = {63'd0, ub < ua};
      default:             r = '0;
    endcase
    r = r & mask;
    res.data.w64[0] = res.data.w64[0] | (r << (l * w));
    if (sat) begin
      res.sat = res.sat | 8'(((1 << (w / 8)) - 1) << (l * w / 8));
    end
  end
  return res;
endfunction

`endif

/* bench/tb_simd_alu.sv */
//////////////////////////////////////////////////
// Testbench for the SIMD ALU top level
// Expected values come from alu_ref.svh. Handshake
// timing is checked by concurrent assertions.
//////////////////////////////////////////////////
`timescale 1ns/1ps

module tb_simd_alu;

  `include "alu_ref.svh"

  localparam int ACK_LIMIT = 20;

  logic                    clk, rst_n, cfg_we, req, ack, vxsat, sat_model;
  simd_alu_pkg::vew_e      cfg_vew, cur_vew;
  simd_alu_pkg::vew_e      widths [4];
  simd_alu_pkg::alu_req_t  req_data;
  simd_alu_pkg::alu_word_u result;
  string                   test_name;
  int                      test_errs, total_errs, tests_run, tests_failed;
  logic [63:0]             a, b;

  simd_alu_top #(
    .RESET_VEW (simd_alu_pkg::EW64)
  ) dut (
    .clk_i      (clk),
    .rst_n_i    (rst_n),
    .cfg_we_i   (cfg_we),
    .cfg_vew_i  (cfg_vew),
    .req_i      (req),
    .req_data_i (req_data),
    .ack_o      (ack),
    .result_o   (result),
    .vxsat_o    (vxsat)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  //////////////////////////////////////////////////
  // Handshake timing
  //////////////////////////////////////////////////
  assert property (@(posedge clk) disable iff (!rst_n) req && !ack |=> ack)
    else begin
      $display("%s: ack did not rise one cycle after the request", test_name);
      test_errs++;
    end

  assert property (@(posedge clk) disable iff (!rst_n) ack && $past(ack) |-> $stable(result))
    else begin
      $display("%s: result changed while ack was high", test_name);
      test_errs++;
    end

  assert property (@(posedge clk) disable iff (!rst_n) ack && !req |=> !ack)
    else begin
      $display("%s: ack did not fall one cycle after req fell", test_name);
      test_errs++;
    end

  function automatic logic [63:0] rand_word();
    return {$urandom, $urandom};
  endfunction

  task automatic check_eq(input string what, input logic [63:0] exp, input logic [63:0] act);
    assert (act === exp) else begin
      $display("FAIL %s: %s expected %h, actual %h", test_name, what, exp, act);
      test_errs++;
    end
  endtask

  task automatic start_test(input string name);
    test_name = name;
    test_errs = 0;
  endtask

  task automatic finish_test();
    tests_run++;
    total_errs += test_errs;
    if (test_errs == 0) begin
      $display("test %s: passed", test_name);
    end else begin
      $display("test %s: failed with %0d errors", test_name, test_errs);
      tests_failed++;
    end
    test_errs = 0;
  endtask

  // Write clears the sticky flag as well
  task automatic set_width(input simd_alu_pkg::vew_e w);
    @(posedge clk);
    cfg_we  <= 1'b1;
    cfg_vew <= w;
    @(posedge clk);
    cfg_we    <= 1'b0;
    cur_vew   = w;
    sat_model = 1'b0;
    @(negedge clk);
    check_eq("vxsat after config write", 64'(sat_model), 64'(vxsat));
  endtask

  // One full four-phase transfer, req held a few random extra cycles
  task automatic run_op(input simd_alu_pkg::alu_op_e op, input logic [63:0] opa,
                        input logic [63:0] opb);
    simd_alu_pkg::alu_res_t exp;
    int                     cycles;
    int unsigned            hold;
    exp  = ref_result(op, cur_vew, opa, opb);
    hold = $urandom_range(3, 0);
    @(posedge clk);
    req_data.op  <= op;
    req_data.opa <= opa;
    req_data.opb <= opb;
    req          <= 1'b1;
    cycles = 0;
    @(negedge clk);
    while (ack !== 1'b1 && cycles < ACK_LIMIT) begin
      @(negedge clk);
      cycles++;
    end
    if (ack !== 1'b1) begin
      $display("%s: no ack within %0d cycles for %s", test_name, ACK_LIMIT, op.name());
      test_errs++;
    end else begin
      sat_model = sat_model | (|exp.sat);
      check_eq($sformatf("%s result", op.name()), exp.data, result);
      check_eq($sformatf("%s vxsat", op.name()), 64'(sat_model), 64'(vxsat));
    end
    // New operands under the held request must not reach the result
    @(posedge clk);
    req_data.opa <= rand_word();
    req_data.opb <= rand_word();
    repeat (hold) @(posedge clk);
    @(posedge clk);
    req <= 1'b0;
    cycles = 0;
    @(negedge clk);
    while (ack !== 1'b0 && cycles < ACK_LIMIT) begin
      @(negedge clk);
      cycles++;
    end
    if (ack !== 1'b0) begin
      $display("%s: ack still high %0d cycles after req fell", test_name, ACK_LIMIT);
      test_errs++;
    end
  endtask

  initial begin
    void'($urandom(17));
    rst_n     = 1'b0;
    cfg_we    = 1'b0;
    cfg_vew   = simd_alu_pkg::EW64;
    req       = 1'b0;
    req_data  = '0;
    cur_vew   = simd_alu_pkg::EW64;
    sat_model = 1'b0;
    widths    = '{simd_alu_pkg::EW8, simd_alu_pkg::EW16, simd_alu_pkg::EW32,
                  simd_alu_pkg::EW64};
    test_errs    = 0;
    total_errs   = 0;
    tests_run    = 0;
    tests_failed = 0;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;

    start_test("reset_and_logic");
    @(negedge clk);
    check_eq("ack after reset", 64'd0, 64'(ack));
    check_eq("vxsat after reset", 64'd0, 64'(vxsat));
    check_eq("result after reset", 64'd0, result);
    repeat (3) begin
      run_op(simd_alu_pkg::AND, rand_word(), rand_word());
      run_op(simd_alu_pkg::OR, rand_word(), rand_word());
      run_op(simd_alu_pkg::XOR, rand_word(), rand_word());
    end
    finish_test();

    start_test("wrap_arith");
    foreach (widths[i]) begin
      set_width(widths[i]);
      repeat (3) begin
        run_op(simd_alu_pkg::ADD, rand_word(), rand_word());
        run_op(simd_alu_pkg::SUB, rand_word(), rand_word());
        run_op(simd_alu_pkg::RSUB, rand_word(), rand_word());
      end
    end
    finish_test();

    // Byte lanes first, one edge case per call
    start_test("saturation");
    set_width(simd_alu_pkg::EW8);
    run_op(simd_alu_pkg::SADDU, {8{8'h20}}, {8{8'h10}});
    run_op(simd_alu_pkg::SADDU, {8{8'hf0}}, {8{8'h20}});
    run_op(simd_alu_pkg::SADD, {8{8'h70}}, {8{8'h20}});
    run_op(simd_alu_pkg::SADD, {8{8'h80}}, {8{8'hff}});
    run_op(simd_alu_pkg::SSUBU, {8{8'h20}}, {8{8'h10}});
    run_op(simd_alu_pkg::SSUB, {8{8'h01}}, {8{8'h80}});
    run_op(simd_alu_pkg::SSUB, {8{8'hff}}, {8{8'h7f}});
    run_op(simd_alu_pkg::ADD, {8{8'h01}}, {8{8'h02}});
    foreach (widths[i]) begin
      set_width(widths[i]);
      repeat (2) begin
        run_op(simd_alu_pkg::SADDU, rand_word(), rand_word());
        run_op(simd_alu_pkg::SADD, rand_word(), rand_word());
        run_op(simd_alu_pkg::SSUBU, rand_word(), rand_word());
        run_op(simd_alu_pkg::SSUB, rand_word(), rand_word());
      end
    end
    set_width(simd_alu_pkg::EW64);
    finish_test();

    // Upper bits of every shift field are set
    start_test("shifts");
    foreach (widths[i]) begin
      set_width(widths[i]);
      repeat (3) begin
        run_op(simd_alu_pkg::SLL, rand_word() | {8{8'hf8}}, rand_word());
        run_op(simd_alu_pkg::SRL, rand_word() | {8{8'hf8}}, rand_word());
        run_op(simd_alu_pkg::SRA, rand_word() | {8{8'hf8}}, rand_word());
      end
    end
    finish_test();

    start_test("min_max_compare");
    foreach (widths[i]) begin
      set_width(widths[i]);
      a = rand_word() | {8{8'h80}};
      b = rand_word() & {8{8'h7f}};
      for (int k = 0; k < 2; k++) begin
        run_op(simd_alu_pkg::MIN, a, b);
        run_op(simd_alu_pkg::MINU, a, b);
        run_op(simd_alu_pkg::MAX, a, b);
        run_op(simd_alu_pkg::MAXU, a, b);
        run_op(simd_alu_pkg::MSLT, a, b);
        run_op(simd_alu_pkg::MSLTU, a, b);
        run_op(simd_alu_pkg::MSNE, a, b);
        {a, b} = {b, a};
      end
      run_op(simd_alu_pkg::MSEQ, a, a);
      run_op(simd_alu_pkg::MSEQ, a, b);
      run_op(simd_alu_pkg::MSNE, b, b);
    end
    finish_test();

    start_test("handshake");
    repeat (6) begin
      run_op(simd_alu_pkg::XOR, rand_word(), rand_word());
      run_op(simd_alu_pkg::SADD, rand_word(), rand_word());
      run_op(simd_alu_pkg::MAXU, rand_word(), rand_word());
    end
    finish_test();

    total_errs += test_errs;
    $display("%0d tests, %0d passed, %0d failed, %0d errors", tests_run,
             tests_run - tests_failed, tests_failed, total_errs);
    if (total_errs == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

/* verilog/simd_alu_top.sv */
//////////////////////////////////////////////////
// 64-bit SIMD ALU with a four-phase req/ack port
// Result is valid while ack is high. Configure only
// when req and ack are both low.
//////////////////////////////////////////////////
`timescale 1ns/1ps

module simd_alu_top #(
  parameter simd_alu_pkg::vew_e RESET_VEW = simd_alu_pkg::EW64
) (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  logic                    cfg_we_i,
  input  simd_alu_pkg::vew_e      cfg_vew_i,
  input  logic                    req_i,
  input  simd_alu_pkg::alu_req_t  req_data_i,
  output logic                    ack_o,
  output simd_alu_pkg::alu_word_u result_o,
  output logic                    vxsat_o
);

  simd_alu_pkg::vew_e                  vew;
  simd_alu_pkg::alu_res_t              arith_res, cmp_res, lsh_res;
  logic                                sat_update;
  logic [simd_alu_pkg::LANE_BYTES-1:0] sat_lanes;

  alu_csr #(
    .RESET_VEW (RESET_VEW)
  ) u_csr (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .cfg_we_i     (cfg_we_i),
    .cfg_vew_i    (cfg_vew_i),
    .sat_update_i (sat_update),
    .sat_lanes_i  (sat_lanes),
    .vew_o        (vew),
    .vxsat_o      (vxsat_o)
  );

  alu_issue_ctrl u_ctrl (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .req_i        (req_i),
    .op_i         (req_data_i.op),
    .arith_i      (arith_res),
    .cmp_i        (cmp_res),
    .lsh_i        (lsh_res),
    .ack_o        (ack_o),
    .result_o     (result_o),
    .sat_update_o (sat_update),
    .sat_lanes_o  (sat_lanes)
  );

  alu_arith u_arith (
    .req_i (req_data_i),
    .vew_i (vew),
    .res_o (arith_res)
  );

  alu_compare u_cmp (
    .req_i (req_data_i),
    .vew_i (vew),
    .res_o (cmp_res)
  );

  alu_logic_shift u_lsh (
    .req_i (req_data_i),
    .vew_i (vew),
    .res_o (lsh_res)
  );

endmodule

/* verilog/alu_logic_shift.sv */
//////////////////////////////////////////////////
// Bitwise logic on the full word, per-lane shifts
// Shift amount is the low log2(lane width) bits
// of lane a. Lane b is the shifted value.
//////////////////////////////////////////////////
`timescale 1ns/1ps

module alu_logic_shift (
  input  simd_alu_pkg::alu_req_t req_i,
  input  simd_alu_pkg::vew_e     vew_i,
  output simd_alu_pkg::alu_res_t res_o
);

  simd_alu_pkg::alu_word_u opa, opb, res;

  assign opa = req_i.opa;
  assign opb = req_i.opb;

  always_comb begin
    res = '0;
    case (req_i.op)
      simd_alu_pkg::AND: res.w64[0] = opa.w64[0] & opb.w64[0];
      simd_alu_pkg::OR:  res.w64[0] = opa.w64[0] | opb.w64[0];
      simd_alu_pkg::XOR: res.w64[0] = opa.w64[0] ^ opb.w64[0];
      simd_alu_pkg::SLL: case (vew_i)
        simd_alu_pkg::EW8:  for (int l = 0; l < 8; l++) res.w8[l] = opb.w8[l] << opa.w8[l][2:0];
        simd_alu_pkg::EW16: for (int l = 0; l < 4; l++) res.w16[l] = opb.w16[l] << opa.w16[l][3:0];
        simd_alu_pkg::EW32: for (int l = 0; l < 2; l++) res.w32[l] = opb.w32[l] << opa.w32[l][4:0];
        default:            res.w64[0] = opb.w64[0] << opa.w64[0][5:0];
      endcase
      simd_alu_pkg::SRL: case (vew_i)
        simd_alu_pkg::EW8:  for (int l = 0; l < 8; l++) res.w8[l] = opb.w8[l] >> opa.w8[l][2:0];
        simd_alu_pkg::EW16: for (int l = 0; l < 4; l++) res.w16[l] = opb.w16[l] >> opa.w16[l][3:0];
        simd_alu_pkg::EW32: for (int l = 0; l < 2; l++) res.w32[l] = opb.w32[l] >> opa.w32[l][4:0];
        default:            res.w64[0] = opb.w64[0] >> opa.w64[0][5:0];
      endcase
      // Arithmetic shift keeps the lane sign
      simd_alu_pkg::SRA: case (vew_i)
        simd_alu_pkg::EW8:
          for (int l = 0; l < 8; l++) res.w8[l] = $signed(opb.w8[l]) >>> opa.w8[l][2:0];
        simd_alu_pkg::EW16:
          for (int l = 0; l < 4; l++) res.w16[l] = $signed(opb.w16[l]) >>> opa.w16[l][3:0];
        simd_alu_pkg::EW32:
          for (int l = 0; l < 2; l++) res.w32[l] = $signed(opb.w32[l]) >>> opa.w32[l][4:0];
        default: res.w64[0] = $signed(opb.w64[0]) >>> opa.w64[0][5:0];
      endcase
      default: ;
    endcase
  end

  assign res_o.data = res;
  assign res_o.sat  = '0;

endmodule

/* verilog/alu_compare.sv */
//////////////////////////////////////////////////
// Min/max and compares, all testing b < a per lane
// Compare outcome sits in bit 0 of each lane.
//////////////////////////////////////////////////
`timescale 1ns/1ps

module alu_compare (
  input  simd_alu_pkg::alu_req_t req_i,
  input  simd_alu_pkg::vew_e     vew_i,
  output simd_alu_pkg::alu_res_t res_o
);

  simd_alu_pkg::alu_word_u               opa, opb, res;
  logic [simd_alu_pkg::LANE_BYTES-1:0]   less, equal, flag;
  logic                                  is_signed, is_max;

  assign opa       = req_i.opa;
  assign opb       = req_i.opb;
  assign is_signed = req_i.op inside {simd_alu_pkg::MIN, simd_alu_pkg::MAX, simd_alu_pkg::MSLT};
  assign is_max    = req_i.op inside {simd_alu_pkg::MAX, simd_alu_pkg::MAXU};

  // Only the lowest byte index of each lane is meaningful
  always_comb begin
    less  = '0;
    equal = '0;
    case (vew_i)
      simd_alu_pkg::EW8: for (int l = 0; l < 8; l++) begin
        less[l]  = $signed({is_signed & opb.w8[l][7], opb.w8[l]}) <
                   $signed({is_signed & opa.w8[l][7], opa.w8[l]});
        equal[l] = opb.w8[l] == opa.w8[l];
      end
      simd_alu_pkg::EW16: for (int l = 0; l < 4; l++) begin
        less[2*l]  = $signed({is_signed & opb.w16[l][15], opb.w16[l]}) <
                     $signed({is_signed & opa.w16[l][15], opa.w16[l]});
        equal[2*l] = opb.w16[l] == opa.w16[l];
      end
      simd_alu_pkg::EW32: for (int l = 0; l < 2; l++) begin
        less[4*l]  = $signed({is_signed & opb.w32[l][31], opb.w32[l]}) <
                     $signed({is_signed & opa.w32[l][31], opa.w32[l]});
        equal[4*l] = opb.w32[l] == opa.w32[l];
      end
      default: begin
        less[0]  = $signed({is_signed & opb.w64[0][63], opb.w64[0]}) <
                   $signed({is_signed & opa.w64[0][63], opa.w64[0]});
        equal[0] = opb.w64[0] == opa.w64[0];
      end
    endcase
  end

  always_comb begin
    case (req_i.op)
      simd_alu_pkg::MSEQ: flag = equal;
      simd_alu_pkg::MSNE: flag = ~equal;
      default:            flag = less;
    endcase
  end

  always_comb begin
    res = '0;
    if (req_i.op inside {simd_alu_pkg::MIN, simd_alu_pkg::MINU,
                         simd_alu_pkg::MAX, simd_alu_pkg::MAXU}) begin
      case (vew_i)
        simd_alu_pkg::EW8:
          for (int l = 0; l < 8; l++) res.w8[l] = (less[l] ^ is_max) ? opb.w8[l] : opa.w8[l];
        simd_alu_pkg::EW16:
          for (int l = 0; l < 4; l++)
            res.w16[l] = (less[2*l] ^ is_max) ? opb.w16[l] : opa.w16[l];
        simd_alu_pkg::EW32:
          for (int l = 0; l < 2; l++)
            res.w32[l] = (less[4*l] ^ is_max) ? opb.w32[l] : opa.w32[l];
        default: res.w64[0] = (less[0] ^ is_max) ? opb.w64[0] : opa.w64[0];
      endcase
    end else if (req_i.op inside {simd_alu_pkg::MSEQ, simd_alu_pkg::MSNE,
                                  simd_alu_pkg::MSLT, simd_alu_pkg::MSLTU}) begin
      case (vew_i)
        simd_alu_pkg::EW8:  for (int l = 0; l < 8; l++) res.w8[l][0] = flag[l];
        simd_alu_pkg::EW16: for (int l = 0; l < 4; l++) res.w16[l][0] = flag[2*l];
        simd_alu_pkg::EW32: for (int l = 0; l < 2; l++) res.w32[l][0] = flag[4*l];
        default:            res.w64[0][0] = flag[0];
      endcase
    end
  end

  assign res_o.data = res;
  assign res_o.sat  = '0;

endmodule

/* verilog/alu_arith.sv */
//////////////////////////////////////////////////
// Wrapping and saturating add/subtract per lane
// SUB and SSUB give b minus a, RSUB gives a minus b.
// Other operations return zero.
//////////////////////////////////////////////////
`timescale 1ns/1ps

module alu_arith (
  input  simd_alu_pkg::alu_req_t req_i,
  input  simd_alu_pkg::vew_e     vew_i,
  output simd_alu_pkg::alu_res_t res_o
);

  logic [3:0][simd_alu_pkg::ELEN-1:0]       wres;
  logic [3:0][simd_alu_pkg::LANE_BYTES-1:0] wsat;

  ///////////////////////////////////////////////////
  // One lane set per element width
  ///////////////////////////////////////////////////
  for (genvar g = 0; g < 4; g++) begin : g_width
    localparam int unsigned W   = 8 << g;
    localparam int unsigned N   = simd_alu_pkg::ELEN / W;
    localparam int unsigned BPL = W / 8;

    for (genvar l = 0; l < N; l++) begin : g_lane
      logic [W-1:0] a, b, smax, smin, lane_res;
      logic [W:0]   sum, dif;
      logic         lane_sat;

      assign a    = req_i.opa.w64[0][l*W +: W];
      assign b    = req_i.opb.w64[0][l*W +: W];
      assign sum  = {1'b0, a} + {1'b0, b};
      // Borrow out lands in bit W
      assign dif  = {1'b0, b} - {1'b0, a};
      assign smax = {1'b0, {(W-1){1'b1}}};
      assign smin = {1'b1, {(W-1){1'b0}}};

      always_comb begin
        lane_res = '0;
        lane_sat = 1'b0;
        case (req_i.op)
          simd_alu_pkg::ADD:  lane_res = sum[W-1:0];
          simd_alu_pkg::SUB:  lane_res = dif[W-1:0];
          simd_alu_pkg::RSUB: lane_res = a - b;
          simd_alu_pkg::SADDU: begin
            lane_sat = sum[W];
            lane_res = lane_sat ? '1 : sum[W-1:0];
          end
          simd_alu_pkg::SADD: begin
            lane_sat = (a[W-1] == b[W-1]) && (sum[W-1] != a[W-1]);
            lane_res = lane_sat ? (a[W-1] ? smin : smax) : sum[W-1:0];
          end
          simd_alu_pkg::SSUBU: begin
            lane_sat = dif[W];
            lane_res = lane_sat ? '0 : dif[W-1:0];
          end
          simd_alu_pkg::SSUB: begin
            // Overflow only when signs differ
            lane_sat = (a[W-1] != b[W-1]) && (dif[W-1] != b[W-1]);
            lane_res = lane_sat ? (b[W-1] ? smin : smax) : dif[W-1:0];
          end
          default: ;
        endcase
      end

      assign wres[g][l*W +: W]     = lane_res;
      assign wsat[g][l*BPL +: BPL] = {BPL{lane_sat}};
    end
  end

  assign res_o.data = wres[vew_i];
  assign res_o.sat  = wsat[vew_i];

endmodule

/* verilog/alu_issue_ctrl.sv */
//////////////////////////////////////////////////
// Four-phase req/ack controller and result register
// One operation in flight. Operands must stay stable
// until ack rises.
//////////////////////////////////////////////////
`timescale 1ns/1ps

module alu_issue_ctrl (
  input  logic                                  clk_i,
  input  logic                                  rst_n_i,
  input  logic                                  req_i,
  input  simd_alu_pkg::alu_op_e                 op_i,
  input  simd_alu_pkg::alu_res_t                arith_i,
  input  simd_alu_pkg::alu_res_t                cmp_i,
  input  simd_alu_pkg::alu_res_t                lsh_i,
  output logic                                  ack_o,
  output simd_alu_pkg::alu_word_u               result_o,
  output logic                                  sat_update_o,
  output logic [simd_alu_pkg::LANE_BYTES-1:0]   sat_lanes_o
);

  typedef enum logic {
    ST_IDLE,
    ST_ACK
  } state_e;

  state_e                  state_q, state_d;
  simd_alu_pkg::alu_res_t  sel_res;
  simd_alu_pkg::alu_word_u result_q;
  logic                    capture;

  // Unit select
  always_comb begin
    case (simd_alu_pkg::unit_of(op_i))
      simd_alu_pkg::UNIT_ARITH: sel_res = arith_i;
      simd_alu_pkg::UNIT_CMP:   sel_res = cmp_i;
      default:                  sel_res = lsh_i;
    endcase
  end

  assign capture = (state_q == ST_IDLE) && req_i;

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: if (req_i) state_d = ST_ACK;
      ST_ACK:  if (!req_i) state_d = ST_IDLE;
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q  <= ST_IDLE;
      result_q <= '0;
    end else begin
      state_q <= state_d;
      if (capture) begin
        result_q <= sel_res.data;
      end
    end
  end

  assign ack_o        = (state_q == ST_ACK);
  assign result_o     = result_q;
  assign sat_update_o = capture;
  assign sat_lanes_o  = sel_res.sat;

endmodule

/* verilog/alu_csr.sv */
//////////////////////////////////////////////////
// Element width and sticky saturation flag
// A configuration write takes effect next cycle and
// clears the flag. Writes must not overlap a request.
//////////////////////////////////////////////////
`timescale 1ns/1ps

module alu_csr #(
  parameter simd_alu_pkg::vew_e RESET_VEW = simd_alu_pkg::EW64
) (
  input  logic                                  clk_i,
  input  logic                                  rst_n_i,
  input  logic                                  cfg_we_i,
  input  simd_alu_pkg::vew_e                    cfg_vew_i,
  input  logic                                  sat_update_i,
  input  logic [simd_alu_pkg::LANE_BYTES-1:0]   sat_lanes_i,
  output simd_alu_pkg::vew_e                    vew_o,
  output logic                                  vxsat_o
);

  simd_alu_pkg::vew_e vew_q;
  logic               vxsat_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      vew_q   <= RESET_VEW;
      vxsat_q <= 1'b0;
    end else if (cfg_we_i) begin
      vew_q   <= cfg_vew_i;
      vxsat_q <= 1'b0;
    end else if (sat_update_i && |sat_lanes_i) begin
      // Sticky until the next configuration write
      vxsat_q <= 1'b1;
    end
  end

  assign vew_o   = vew_q;
  assign vxsat_o = vxsat_q;

endmodule

/* verilog/simd_alu_pkg.sv */
//////////////////////////////////////////////////
// Shared types of the 64-bit SIMD ALU
// Lane views assume a 64-bit datapath and 8-bit lanes
// as the smallest element. Compare results use only
// bit 0 of each lane.
//////////////////////////////////////////////////
package simd_alu_pkg;

  localparam int unsigned ELEN       = 64;
  localparam int unsigned LANE_BYTES = ELEN / 8;

  typedef enum logic [4:0] {
    AND,
    OR,
    XOR,
    ADD,
    SUB,
    RSUB,
    SADDU,
    SADD,
    SSUBU,
    SSUB,
    SLL,
    SRL,
    SRA,
    MIN,
    MINU,
    MAX,
    MAXU,
    MSEQ,
    MSNE,
    MSLT,
    MSLTU
  } alu_op_e;

  // Encoding doubles as log2 of the lane width in bytes
  typedef enum logic [1:0] {
    EW8,
    EW16,
    EW32,
    EW64
  } vew_e;

  typedef enum logic [1:0] {
    UNIT_ARITH,
    UNIT_CMP,
    UNIT_LSH
  } alu_unit_e;

  typedef union packed {
    logic [0:0][ELEN-1:0]           w64;
    logic [1:0][ELEN/2-1:0]         w32;
    logic [3:0][ELEN/4-1:0]         w16;
    logic [LANE_BYTES-1:0][7:0]     w8;
  } alu_word_u;

  typedef struct packed {
    alu_op_e   op;
    alu_word_u opa;
    alu_word_u opb;
  } alu_req_t;

  // One sat bit per byte, all bytes of a saturated lane set
  typedef struct packed {
    alu_word_u             data;
    logic [LANE_BYTES-1:0] sat;
  } alu_res_t;

  function automatic alu_unit_e unit_of(alu_op_e op);
    case (op)
      ADD, SUB, RSUB, SADDU, SADD, SSUBU, SSUB: return UNIT_ARITH;
      MIN, MINU, MAX, MAXU, MSEQ, MSNE, MSLT, MSLTU: return UNIT_CMP;
      default: return UNIT_LSH;
    endcase
  endfunction

endpackage
